// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_hci
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_TEXT = Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
+incdir+tests
source/hci_pkg.sv
source/hci_queue_if.sv
source/sync_fifo.sv
source/cmd_queue.sv
source/resp_queue.sv
source/hci_csr.sv
source/hci_top.sv
tests/tb_hci.sv

// File: source/cmd_queue.sv
/* Two COMMAND_PORT words form one command, first word in bits 31:0.
   The completing word waits without ack while the FIFO is full. */
`timescale 1ns/1ns
`default_nettype none

module cmd_queue (
  input  logic          clk_i,
  input  logic          rst_ni,
  hci_queue_if.queue    q_if,
  output logic          cmd_rvalid_o,
  output hci_pkg::cmd_t cmd_rdata_o,
  input  logic          cmd_rready_i
);
  import hci_pkg::*;

  logic      phase_q;  // First word held
  csr_data_t lo_word_q;
  cmd_t      cmd_q;
  logic      push_q;
  logic      ack_q;
  logic      accept;
  logic      fifo_full;
  logic      fifo_empty;
  depth_t    fill;
  depth_t    free;

  // First word always fits, second one needs a free entry
  assign accept = q_if.port_req && (!phase_q || !fifo_full);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
      push_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= accept;
      if (q_if.flush) begin
        phase_q <= 1'b0;
        push_q  <= 1'b0;
      end else begin
        push_q <= accept && phase_q;  // Lands in FIFO with the ack
        if (accept) phase_q <= !phase_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !phase_q) lo_word_q <= q_if.port_wdata;
    if (accept && phase_q) cmd_q <= {q_if.port_wdata, lo_word_q};
  end

  sync_fifo #(
    .DEPTH(QUEUE_DEPTH),
    .WIDTH(CMD_FIFO_WIDTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (q_if.flush),
    .push_i  (push_q),
    .data_i  (cmd_q),
    .pop_i   (cmd_rvalid_o && cmd_rready_i),
    .data_o  (cmd_rdata_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .count_o (fill)
  );

  assign cmd_rvalid_o = !fifo_empty;

  // Empty-space trigger
  assign free           = depth_t'(QUEUE_DEPTH) - fill;
  assign q_if.thld_trig = (thld_t'(free) >= q_if.thld);

  assign q_if.port_ack   = ack_q;
  assign q_if.port_rdata = lo_word_q;
  assign q_if.port_empty = fifo_empty;
  assign q_if.fill       = fill;

endmodule

`default_nettype wire

// File: source/hci_csr.sv
/* Host holds csr_req_i until an ack and drops it the cycle after.
   Port accesses are answered by the queues, all other registers here. */
`timescale 1ns/1ns
`default_nettype none

module hci_csr (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_i,
  input  logic               csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::csr_data_t csr_wr_data_i,
  output logic               csr_wr_ack_o,
  output logic               csr_rd_ack_o,
  output hci_pkg::csr_data_t csr_rd_data_o,
  output logic               csr_err_o,
  hci_queue_if.csr           cmd_if,
  hci_queue_if.csr           resp_if,
  output logic               irq_o
);
  import hci_pkg::*;

  logic        active;
  logic        wr;
  logic        rd;
  logic        reg_wr;
  logic        reg_rd;
  logic        addr_ok;
  csr_data_t   reg_rdata;
  logic        reg_wr_ack_q;
  logic        reg_rd_ack_q;
  logic        err_q;
  csr_data_t   rd_data_q;
  thld_t       cmd_thld_q;
  thld_t       resp_thld_q;
  logic [1:0]  intr_status_q;  // [0] cmd ready, [1] resp ready
  logic [1:0]  intr_enable_q;
  logic [1:0]  intr_clr;
  logic [1:0]  qrst_start;     // [0] cmd, [1] resp
  logic [1:0]  qrst_busy;
  qrst_state_e qrst_q [2];

  // Ack cycle must not count as a new access
  assign active = csr_req_i && !csr_wr_ack_o && !csr_rd_ack_o;
  assign wr     = active && csr_req_is_wr_i;
  assign rd     = active && !csr_req_is_wr_i;
  assign reg_wr = wr && (csr_addr_i != ADDR_COMMAND_PORT);
  assign reg_rd = rd && (csr_addr_i != ADDR_RESPONSE_PORT);

  assign cmd_if.port_req    = wr && (csr_addr_i == ADDR_COMMAND_PORT);
  assign cmd_if.port_wdata  = csr_wr_data_i;
  assign resp_if.port_req   = rd && (csr_addr_i == ADDR_RESPONSE_PORT);
  assign resp_if.port_wdata = csr_wr_data_i;

  always_comb begin
    reg_rdata = '0;
    addr_ok   = 1'b1;
    case (csr_addr_i)
      ADDR_RESET_CONTROL:   reg_rdata = {29'b0, qrst_busy, 1'b0};
      ADDR_INTR_STATUS:     reg_rdata = {30'b0, intr_status_q};
      ADDR_INTR_ENABLE:     reg_rdata = {30'b0, intr_enable_q};
      ADDR_QUEUE_THLD_CTRL: reg_rdata = {16'b0, resp_thld_q, cmd_thld_q};
      ADDR_QUEUE_STATUS:    reg_rdata = {9'b0, resp_if.fill, 9'b0, cmd_if.fill};
      default:              addr_ok = 1'b0;
    endcase
  end

  assign intr_clr = (reg_wr && csr_addr_i == ADDR_INTR_STATUS) ? csr_wr_data_i[1:0] : 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_wr_ack_q  <= 1'b0;
      reg_rd_ack_q  <= 1'b0;
      err_q         <= 1'b0;
      cmd_thld_q    <= '0;
      resp_thld_q   <= '0;
      intr_status_q <= '0;
      intr_enable_q <= '0;
    end else begin
      reg_wr_ack_q <= reg_wr;
      reg_rd_ack_q <= reg_rd;
      err_q <= (reg_wr && (!addr_ok || csr_addr_i == ADDR_QUEUE_STATUS)) ||
               (reg_rd && !addr_ok);
      if (reg_wr && csr_addr_i == ADDR_INTR_ENABLE) intr_enable_q <= csr_wr_data_i[1:0];
      if (reg_wr && csr_addr_i == ADDR_QUEUE_THLD_CTRL) begin
        cmd_thld_q  <= csr_wr_data_i[7:0];
        resp_thld_q <= csr_wr_data_i[15:8];
      end
      // Set beats clear
      intr_status_q <= (intr_status_q & ~intr_clr) | {resp_if.thld_trig, cmd_if.thld_trig};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_rd) rd_data_q <= reg_rdata;
  end

  // Soft reset per queue, bit stays set for flush and done
  assign qrst_start[0] = reg_wr && (csr_addr_i == ADDR_RESET_CONTROL) && csr_wr_data_i[1];
  assign qrst_start[1] = reg_wr && (csr_addr_i == ADDR_RESET_CONTROL) && csr_wr_data_i[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2; i++) qrst_q[i] <= QRST_IDLE;
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (qrst_q[i])
          QRST_IDLE:  if (qrst_start[i]) qrst_q[i] <= QRST_FLUSH;
          QRST_FLUSH: qrst_q[i] <= QRST_DONE;
          default:    qrst_q[i] <= QRST_IDLE;
        endcase
      end
    end
  end

  assign qrst_busy      = {qrst_q[1] != QRST_IDLE, qrst_q[0] != QRST_IDLE};
  assign cmd_if.flush   = (qrst_q[0] == QRST_FLUSH);
  assign resp_if.flush  = (qrst_q[1] == QRST_FLUSH);
  assign cmd_if.thld    = cmd_thld_q;
  assign resp_if.thld   = resp_thld_q;

  assign csr_wr_ack_o  = reg_wr_ack_q | cmd_if.port_ack;
  assign csr_rd_ack_o  = reg_rd_ack_q | resp_if.port_ack;
  assign csr_rd_data_o = resp_if.port_ack ? resp_if.port_rdata : rd_data_q;
  assign csr_err_o     = err_q | (resp_if.port_ack & resp_if.port_empty);
  assign irq_o         = |(intr_status_q & intr_enable_q);

  // Queue and register acks together give one pulse per request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (csr_wr_ack_o || csr_rd_ack_o) |=> !(csr_wr_ack_o || csr_rd_ack_o))
    else $error("second ack for one request");

endmodule

`default_nettype wire

// File: source/hci_pkg.sv
/* Shared widths, register map and types of the reduced I3C HCI.
   Queue depth must stay a power of two. */
`default_nettype none

package hci_pkg;

  localparam int unsigned QUEUE_DEPTH     = 64;
  localparam int unsigned CMD_FIFO_WIDTH  = 64;
  localparam int unsigned RESP_FIFO_WIDTH = 32;

  localparam int unsigned CSR_ADDR_W = 12;
  localparam int unsigned CSR_DATA_W = 32;
  localparam int unsigned THLD_W     = 8;
  localparam int unsigned DEPTH_W    = $clog2(QUEUE_DEPTH + 1);

  typedef logic [CSR_ADDR_W-1:0]      csr_addr_t;
  typedef logic [CSR_DATA_W-1:0]      csr_data_t;
  typedef logic [CMD_FIFO_WIDTH-1:0]  cmd_t;
  typedef logic [RESP_FIFO_WIDTH-1:0] resp_t;
  typedef logic [THLD_W-1:0]          thld_t;
  typedef logic [DEPTH_W-1:0]         depth_t;

  // Register byte offsets
  localparam csr_addr_t ADDR_RESET_CONTROL   = 12'h010;  // [1] cmd, [2] resp
  localparam csr_addr_t ADDR_INTR_STATUS     = 12'h020;  // W1C
  localparam csr_addr_t ADDR_INTR_ENABLE     = 12'h024;
  localparam csr_addr_t ADDR_COMMAND_PORT    = 12'h0C0;
  localparam csr_addr_t ADDR_RESPONSE_PORT   = 12'h0C4;
  localparam csr_addr_t ADDR_QUEUE_THLD_CTRL = 12'h0D0;
  localparam csr_addr_t ADDR_QUEUE_STATUS    = 12'h0D4;

  // Soft reset of one queue
  typedef enum logic [1:0] {
    QRST_IDLE,
    QRST_FLUSH,
    QRST_DONE
  } qrst_state_e;

endpackage

`default_nettype wire

// File: source/hci_queue_if.sv
/* Register file to queue link, one per queue.
   port_req stays high until port_ack, which is registered in the queue. */
`timescale 1ns/1ns
`default_nettype none

interface hci_queue_if;
  import hci_pkg::*;

  logic      port_req;
  csr_data_t port_wdata;
  thld_t     thld;
  logic      flush;

  logic      port_ack;
  csr_data_t port_rdata;
  logic      port_empty;  // With port_ack, access found no data
  depth_t    fill;
  logic      thld_trig;

  modport csr (
    output port_req,
    output port_wdata,
    output thld,
    output flush,
    input  port_ack,
    input  port_rdata,
    input  port_empty,
    input  fill,
    input  thld_trig
  );

  modport queue (
    input  port_req,
    input  port_wdata,
    input  thld,
    input  flush,
    output port_ack,
    output port_rdata,
    output port_empty,
    output fill,
    output thld_trig
  );

endinterface

`default_nettype wire

// File: source/hci_top.sv
/* Reduced I3C HCI with command and response queues only.
   cmd_rvalid_o follows the second COMMAND_PORT word one cycle after its ack. */
`timescale 1ns/1ns
`default_nettype none

module hci_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Software register port
  input  logic               csr_req_i,
  input  logic               csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::csr_data_t csr_wr_data_i,
  output logic               csr_wr_ack_o,
  output logic               csr_rd_ack_o,
  output hci_pkg::csr_data_t csr_rd_data_o,
  output logic               csr_err_o,
  output logic               irq_o,

  // Controller side
  output logic               cmd_rvalid_o,
  output hci_pkg::cmd_t      cmd_rdata_o,
  input  logic               cmd_rready_i,
  input  logic               resp_wvalid_i,
  input  hci_pkg::resp_t     resp_wdata_i,
  output logic               resp_wready_o
);

  hci_queue_if cmd_if ();
  hci_queue_if resp_if ();

  hci_csr u_csr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_req_i       (csr_req_i),
    .csr_req_is_wr_i (csr_req_is_wr_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wr_data_i   (csr_wr_data_i),
    .csr_wr_ack_o    (csr_wr_ack_o),
    .csr_rd_ack_o    (csr_rd_ack_o),
    .csr_rd_data_o   (csr_rd_data_o),
    .csr_err_o       (csr_err_o),
    .cmd_if          (cmd_if),
    .resp_if         (resp_if),
    .irq_o           (irq_o)
  );

  cmd_queue u_cmd_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .q_if         (cmd_if),
    .cmd_rvalid_o (cmd_rvalid_o),
    .cmd_rdata_o  (cmd_rdata_o),
    .cmd_rready_i (cmd_rready_i)
  );

  resp_queue u_resp_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .q_if          (resp_if),
    .resp_wvalid_i (resp_wvalid_i),
    .resp_wdata_i  (resp_wdata_i),
    .resp_wready_o (resp_wready_o)
  );

endmodule

`default_nettype wire

// File: source/resp_queue.sv
/* A port read of an empty queue returns port_empty with zero data.
   A response is readable one cycle after the controller writes it. */
`timescale 1ns/1ns
`default_nettype none

module resp_queue (
  input  logic           clk_i,
  input  logic           rst_ni,
  hci_queue_if.queue     q_if,
  input  logic           resp_wvalid_i,
  input  hci_pkg::resp_t resp_wdata_i,
  output logic           resp_wready_o
);
  import hci_pkg::*;

  logic      fifo_full;
  logic      fifo_empty;
  resp_t     fifo_data;
  depth_t    fill;
  thld_t     eff_thld;
  logic      ack_q;
  logic      empty_q;
  csr_data_t rdata_q;

  assign resp_wready_o = !fifo_full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      empty_q <= 1'b0;
    end else begin
      ack_q   <= q_if.port_req;
      empty_q <= q_if.port_req && fifo_empty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_if.port_req) rdata_q <= fifo_empty ? '0 : fifo_data;
  end

  sync_fifo #(
    .DEPTH(QUEUE_DEPTH),
    .WIDTH(RESP_FIFO_WIDTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (q_if.flush),
    .push_i  (resp_wvalid_i && resp_wready_o),
    .data_i  (resp_wdata_i),
    .pop_i   (q_if.port_req && !fifo_empty),
    .data_o  (fifo_data),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .count_o (fill)
  );

  // Threshold 0 behaves as 1
  assign eff_thld       = (q_if.thld == '0) ? thld_t'(1) : q_if.thld;
  assign q_if.thld_trig = (thld_t'(fill) >= eff_thld);

  assign q_if.port_ack   = ack_q;
  assign q_if.port_rdata = rdata_q;
  assign q_if.port_empty = empty_q;
  assign q_if.fill       = fill;

  // Response offered while full must not raise the fill
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_wvalid_i && fifo_full && !q_if.flush) |=> (q_if.fill <= $past(q_if.fill)))
    else $error("response pushed while full");

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
/* DEPTH must be a power of two; data_o shows the head entry without a read delay.
   Push into a full FIFO is dropped, flush wins over push and pop. */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter int unsigned DEPTH = hci_pkg::QUEUE_DEPTH,
  parameter int unsigned WIDTH = hci_pkg::CMD_FIFO_WIDTH
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o,
  output hci_pkg::depth_t  count_o
);
  import hci_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  depth_t           count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == depth_t'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o && !flush_i))
    else $error("push into full FIFO");
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o))
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// File: tests/tb_hci_tasks.svh
/* Bus, compare and test tasks, included in the tb_hci module body.
   Outputs are sampled on the falling edge, inputs driven on the rising edge. */
`ifndef TB_HCI_TASKS_SVH
`define TB_HCI_TASKS_SVH

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

task automatic note_failure(input string msg);
  $display("%s", msg);
  error_count++;
endtask

task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    error_count++;
  end
endtask

task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%016h, expected 0x%016h", name, got, exp);
    error_count++;
  end
endtask

task automatic check_resp(input string name, input resp_t got, input resp_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    error_count++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    error_count++;
  end
endtask

task automatic report_test(input string name, input int unsigned errs_before);
  if (error_count == errs_before) begin
    $display("%s: passed", name);
  end else begin
    failed_tests++;
    $display("%s: failed with %0d errors", name, error_count - errs_before);
  end
endtask

task automatic start_csr(input logic is_wr, input csr_addr_t addr, input csr_data_t wdata);
  @(posedge clk_i);
  csr_req_i       <= 1'b1;
  csr_req_is_wr_i <= is_wr;
  csr_addr_i      <= addr;
  csr_wr_data_i   <= wdata;
endtask

// Request is dropped on the edge after the ack pulse
task automatic wait_csr_ack(output csr_data_t rdata, output logic err);
  bit seen;
  seen  = 1'b0;
  rdata = '0;
  err   = 1'b1;
  for (int i = 0; i < ACK_TIMEOUT && !seen; i++) begin
    @(negedge clk_i);
    if (csr_wr_ack_o || csr_rd_ack_o) begin
      seen  = 1'b1;
      rdata = csr_rd_data_o;
      err   = csr_err_o;
    end
  end
  if (!seen) note_failure($sformatf("No acknowledge for register 0x%03h", csr_addr_i));
  @(posedge clk_i);
  csr_req_i <= 1'b0;
endtask

task automatic write_csr(input csr_addr_t addr, input csr_data_t wdata);
  csr_data_t rdata;
  logic      err;
  start_csr(1'b1, addr, wdata);
  wait_csr_ack(rdata, err);
  check_bit("csr_err_o", err, 1'b0);
endtask

task automatic read_csr(input csr_addr_t addr, output csr_data_t rdata, output logic err);
  start_csr(1'b0, addr, '0);
  wait_csr_ack(rdata, err);
endtask

task automatic expect_read(input string name, input csr_addr_t addr, input csr_data_t exp);
  csr_data_t data;
  logic      err;
  read_csr(addr, data, err);
  check_bit("csr_err_o", err, 1'b0);
  check_data($sformatf("csr_rd_data_o (%s)", name), data, exp);
endtask

task automatic send_random_cmd();
  csr_data_t lo;
  csr_data_t hi;
  lo = next_random();
  hi = next_random();
  write_csr(ADDR_COMMAND_PORT, lo);
  write_csr(ADDR_COMMAND_PORT, hi);
  cmd_model.push_back({hi, lo});  // First word lands in the low half
endtask

task automatic pop_cmd_check();
  cmd_t        exp;
  int unsigned waited;
  exp    = cmd_model.pop_front();
  waited = 0;
  @(negedge clk_i);
  while (!cmd_rvalid_o && waited < ACK_TIMEOUT) begin
    @(negedge clk_i);
    waited++;
  end
  if (!cmd_rvalid_o) begin
    note_failure("Command queue never presented a command");
  end else begin
    check_cmd("cmd_rdata_o", cmd_rdata_o, exp);
  end
  @(posedge clk_i);
  cmd_rready_i <= 1'b1;
  @(posedge clk_i);
  cmd_rready_i <= 1'b0;
endtask

task automatic drain_cmds();
  while (cmd_model.size() > 0) pop_cmd_check();
  @(negedge clk_i);
  check_bit("cmd_rvalid_o", cmd_rvalid_o, 1'b0);
endtask

task automatic push_random_resp();
  resp_t r;
  r = next_random();
  @(negedge clk_i);
  check_bit("resp_wready_o", resp_wready_o, 1'b1);
  @(posedge clk_i);
  resp_wvalid_i <= 1'b1;
  resp_wdata_i  <= r;
  @(posedge clk_i);
  resp_wvalid_i <= 1'b0;
  resp_model.push_back(r);
endtask

task automatic read_resp_check();
  csr_data_t data;
  logic      err;
  read_csr(ADDR_RESPONSE_PORT, data, err);
  check_bit("csr_err_o", err, 1'b0);
  check_resp("csr_rd_data_o", resp_t'(data), resp_model.pop_front());
endtask

task automatic test_cmd_order();
  int unsigned errs;
  errs = error_count;
  repeat (8) send_random_cmd();
  expect_read("QUEUE_STATUS", ADDR_QUEUE_STATUS, 32'h0000_0008);
  drain_cmds();
  report_test("cmd_order", errs);
endtask

task automatic test_resp_order();
  int unsigned errs;
  csr_data_t   data;
  logic        err;
  errs = error_count;
  repeat (16) push_random_resp();
  repeat (16) read_resp_check();
  read_csr(ADDR_RESPONSE_PORT, data, err);  // Queue now empty
  check_bit("csr_err_o", err, 1'b1);
  check_data("csr_rd_data_o", data, '0);
  report_test("resp_order", errs);
endtask

task automatic test_resp_irq();
  int unsigned errs;
  errs = error_count;
  write_csr(ADDR_QUEUE_THLD_CTRL, 32'h0000_0400);
  write_csr(ADDR_INTR_STATUS, 32'h2);  // Sticky from earlier traffic
  write_csr(ADDR_INTR_ENABLE, 32'h2);
  repeat (3) push_random_resp();
  repeat (3) @(negedge clk_i);
  check_bit("irq_o", irq_o, 1'b0);
  push_random_resp();
  for (int i = 0; i < 8 && !irq_o; i++) @(negedge clk_i);
  check_bit("irq_o", irq_o, 1'b1);
  repeat (4) read_resp_check();
  write_csr(ADDR_INTR_STATUS, 32'h2);
  // Cmd trigger stays set, threshold 0 always met
  expect_read("INTR_STATUS", ADDR_INTR_STATUS, 32'h1);
  @(negedge clk_i);
  check_bit("irq_o", irq_o, 1'b0);
  write_csr(ADDR_INTR_ENABLE, 32'h0);
  report_test("resp_irq", errs);
endtask

task automatic test_cmd_backpressure();
  int unsigned errs;
  csr_data_t   lo;
  csr_data_t   hi;
  csr_data_t   rdata;
  logic        err;
  bit          acked;
  errs  = error_count;
  acked = 1'b0;
  repeat (QUEUE_DEPTH) send_random_cmd();
  expect_read("QUEUE_STATUS", ADDR_QUEUE_STATUS, 32'h0000_0040);
  lo = next_random();
  hi = next_random();
  write_csr(ADDR_COMMAND_PORT, lo);
  start_csr(1'b1, ADDR_COMMAND_PORT, hi);
  repeat (10) begin
    @(negedge clk_i);
    if (csr_wr_ack_o) acked = 1'b1;
  end
  if (acked) note_failure("Write into a full command queue was acknowledged");
  pop_cmd_check();
  cmd_model.push_back({hi, lo});
  wait_csr_ack(rdata, err);
  check_bit("csr_err_o", err, 1'b0);
  drain_cmds();
  report_test("cmd_backpressure", errs);
endtask

task automatic test_resp_reset();
  int unsigned errs;
  errs = error_count;
  repeat (5) push_random_resp();
  expect_read("QUEUE_STATUS", ADDR_QUEUE_STATUS, 32'h0005_0000);
  write_csr(ADDR_RESET_CONTROL, 32'h4);
  resp_model.delete();
  repeat (2) @(posedge clk_i);
  expect_read("RESET_CONTROL", ADDR_RESET_CONTROL, 32'h0);
  expect_read("QUEUE_STATUS", ADDR_QUEUE_STATUS, 32'h0);
  push_random_resp();  // Queue still usable after the flush
  read_resp_check();
  report_test("resp_reset", errs);
endtask

task automatic test_csr_errors();
  int unsigned errs;
  csr_data_t   data;
  logic        err;
  csr_data_t   thld;
  errs = error_count;
  read_csr(12'h100, data, err);
  check_bit("csr_err_o", err, 1'b1);
  check_data("csr_rd_data_o", data, '0);
  thld = next_random();
  write_csr(ADDR_QUEUE_THLD_CTRL, thld);
  expect_read("QUEUE_THLD_CTRL", ADDR_QUEUE_THLD_CTRL, {16'h0, thld[15:0]});
  report_test("csr_errors", errs);
endtask

`endif

// File: tests/tb_hci.sv
/* Directed tests of hci_top, checked against scoreboard queues.
   A watchdog bounds the run time. */
`timescale 1ns/1ns
`default_nettype none

module tb_hci;
  import hci_pkg::*;

  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned CLK_NS      = 8;
  localparam int unsigned ACK_TIMEOUT = 200;  // Cycles

  logic      clk_i;
  logic      rst_ni;
  logic      csr_req_i;
  logic      csr_req_is_wr_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wr_data_i;
  logic      csr_wr_ack_o;
  logic      csr_rd_ack_o;
  csr_data_t csr_rd_data_o;
  logic      csr_err_o;
  logic      irq_o;
  logic      cmd_rvalid_o;
  cmd_t      cmd_rdata_o;
  logic      cmd_rready_i;
  logic      resp_wvalid_i;
  resp_t     resp_wdata_i;
  logic      resp_wready_o;

  int unsigned error_count;
  int unsigned failed_tests;
  logic [31:0] lcg_state;
  cmd_t        cmd_model[$];   // Commands still expected on the controller side
  resp_t       resp_model[$];

  hci_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_req_i       (csr_req_i),
    .csr_req_is_wr_i (csr_req_is_wr_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wr_data_i   (csr_wr_data_i),
    .csr_wr_ack_o    (csr_wr_ack_o),
    .csr_rd_ack_o    (csr_rd_ack_o),
    .csr_rd_data_o   (csr_rd_data_o),
    .csr_err_o       (csr_err_o),
    .irq_o           (irq_o),
    .cmd_rvalid_o    (cmd_rvalid_o),
    .cmd_rdata_o     (cmd_rdata_o),
    .cmd_rready_i    (cmd_rready_i),
    .resp_wvalid_i   (resp_wvalid_i),
    .resp_wdata_i    (resp_wdata_i),
    .resp_wready_o   (resp_wready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  initial begin
    #(NUM_TESTS * 2000 * CLK_NS);
    $display("Watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  `include "tb_hci_tasks.svh"

  initial begin
    error_count  = 0;
    failed_tests = 0;
    lcg_state    = 32'h15a2;
    rst_ni          <= 1'b0;
    csr_req_i       <= 1'b0;
    csr_req_is_wr_i <= 1'b0;
    csr_addr_i      <= '0;
    csr_wr_data_i   <= '0;
    cmd_rready_i    <= 1'b0;
    resp_wvalid_i   <= 1'b0;
    resp_wdata_i    <= '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    test_cmd_order();
    test_resp_order();
    test_resp_irq();
    test_cmd_backpressure();
    test_resp_reset();
    test_csr_errors();

    $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
